// ==== filelist.f ====
axil_pkg.sv
sram_pkg.sv
sram_lfsr.sv
sram_latency_timer.sv
sram_array.sv
sram_ctrl.sv
sram_axil_top.sv
tb_sram_axil.sv

// ==== Bender.yml ====
package:
  name: sram_axil

sources:
  - axil_pkg.sv
  - sram_pkg.sv
  - sram_lfsr.sv
  - sram_latency_timer.sv
  - sram_array.sv
  - sram_ctrl.sv
  - sram_axil_top.sv
  - target: test
    files:
      - tb_sram_axil.sv

// ==== tb_sram_axil.sv ====
`timescale 1ns/1ps

module tb_sram_axil;
  import axil_pkg::*;
  import sram_pkg::*;

  logic clk;
  logic rst;
  axil_ar_t ar;
  logic arvalid, arready;
  axil_r_t r;
  logic rvalid, rready;
  axil_aw_t aw;
  logic awvalid, awready;
  axil_w_t w;
  logic wvalid, wready;
  axil_b_t b;
  logic bvalid, bready;

  logic [31:0] lcg_state = 32'hd81b_3ebb;
  axil_data_t  shadow [MEM_WORDS];  // Expected memory contents

  sram_axil_top sram_axil_top_i (.*);

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  // --------------------
  // Helpers

  function automatic logic [31:0] next_rand();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  task automatic fail_run(input string msg);
    $display("%s", msg);
    $display("TEST FAIL");
    $fatal(1, "Stopping at first error");
  endtask

  task automatic check_eq(input string what, input logic [31:0] exp, input logic [31:0] got);
    assert (got === exp) else begin
      fail_run($sformatf("** Error at %0t: %s expected %h got %h", $time, what, exp, got));
    end
  endtask

  function automatic bit in_range(input axil_addr_t addr);
    return addr < axil_addr_t'(MEM_WORDS * 4);
  endfunction

  task automatic do_write(input axil_addr_t addr, input axil_data_t data, input axil_strb_t strb);
    int cnt;
    int stall;
    word_idx_t idx;
    idx = addr[WORD_IDX_W+1:2];
    @(posedge clk);
    aw      <= axil_aw_t'(addr);
    awvalid <= 1'b1;
    cnt = 0;
    do begin @(negedge clk); cnt++; end while (!awready && cnt < 64);
    if (!awready) fail_run("Timeout waiting for awready");
    @(posedge clk);
    awvalid <= 1'b0;
    w       <= {data, strb};
    wvalid  <= 1'b1;
    cnt = 0;
    do begin @(negedge clk); cnt++; end while (!wready && cnt < 64);
    if (!wready) fail_run("Timeout waiting for wready");
    @(posedge clk);
    wvalid <= 1'b0;
    cnt = 0;
    do begin @(negedge clk); cnt++; end while (!bvalid && cnt < 64);
    if (!bvalid) fail_run("Timeout waiting for bvalid");
    check_eq("write response", in_range(addr) ? RESP_OKAY : RESP_SLVERR, b.resp);
    if (in_range(addr)) begin
      for (int lane = 0; lane < STRB_W; lane++) begin
        if (strb[lane]) shadow[idx][8*lane +: 8] = data[8*lane +: 8];
      end
    end
    stall = next_rand() % 5;  // bready held low
    repeat (stall) @(posedge clk);
    @(posedge clk);
    bready <= 1'b1;
    @(posedge clk);
    bready <= 1'b0;
  endtask

  task automatic do_read(input axil_addr_t addr);
    int cnt;
    int stall;
    axil_data_t exp_data;
    exp_data = in_range(addr) ? shadow[addr[WORD_IDX_W+1:2]] : '0;
    @(posedge clk);
    ar      <= axil_ar_t'(addr);
    arvalid <= 1'b1;
    cnt = 0;
    do begin @(negedge clk); cnt++; end while (!arready && cnt < 64);
    if (!arready) fail_run("Timeout waiting for arready");
    @(posedge clk);
    arvalid <= 1'b0;
    cnt = 0;
    do begin @(negedge clk); cnt++; end while (!rvalid && cnt < 64);
    if (!rvalid) fail_run("Timeout waiting for rvalid");
    check_eq("read data", exp_data, r.data);
    check_eq("read response", in_range(addr) ? RESP_OKAY : RESP_SLVERR, r.resp);
    stall = next_rand() % 5;
    repeat (stall) @(posedge clk);
    @(posedge clk);
    rready <= 1'b1;
    @(posedge clk);
    rready <= 1'b0;
  endtask

  // --------------------
  // Protocol checks

  r_held: assert property (@(posedge clk) disable iff (rst)
    rvalid && !rready |=> rvalid && $stable(r))
    else fail_run($sformatf("** Error at %0t: read response changed while stalled", $time));

  b_held: assert property (@(posedge clk) disable iff (rst)
    bvalid && !bready |=> bvalid && $stable(b))
    else fail_run($sformatf("** Error at %0t: write response changed while stalled", $time));

  ar_blocked: assert property (@(posedge clk) disable iff (rst) rvalid |-> !arready)
    else fail_run("Read address channel open while a read response was pending");

  aw_blocked: assert property (@(posedge clk) disable iff (rst) bvalid |-> !awready)
    else fail_run("Write address channel open while a write response was pending");

  // --------------------
  // Stimulus

  initial begin
    word_idx_t  words [16];
    axil_addr_t wr_addr;
    axil_addr_t rd_addr;
    rst = 1'b1;
    ar = '0;
    arvalid = 1'b0;
    aw = '0;
    awvalid = 1'b0;
    w = '0;
    wvalid = 1'b0;
    rready = 1'b0;
    bready = 1'b0;
    for (int k = 0; k < MEM_WORDS; k++) shadow[k] = '0;
    repeat (8) @(posedge clk);
    rst <= 1'b0;
    @(negedge clk);
    check_eq("ready/valid after reset", 5'b11000, {arready, awready, wready, rvalid, bvalid});

    // Full-strobe writes, reads in random order
    for (int i = 0; i < 16; i++) begin
      words[i] = word_idx_t'(next_rand());
      do_write({22'b0, words[i], 2'(next_rand())}, next_rand(), 4'hf);
    end
    for (int i = 0; i < 16; i++) do_read({22'b0, words[next_rand() % 16], 2'b00});

    // Partial strobes
    for (int i = 0; i < 16; i++) begin
      wr_addr = {22'b0, words[i], 2'b00};
      do_write(wr_addr, next_rand(), axil_strb_t'(next_rand()));
      do_read(wr_addr);
    end

    // Out of range, bit 10 forces the address past the array
    for (int i = 0; i < 4; i++) begin
      do_read(next_rand() | 32'h0000_0400);
      do_write(next_rand() | 32'h0000_0400, next_rand(), 4'hf);
    end
    for (int k = 0; k < MEM_WORDS; k++) do_read(axil_addr_t'(k * 4));

    // Reads and writes together on different words
    for (int i = 0; i < 16; i++) begin
      wr_addr = {22'b0, word_idx_t'(next_rand()), 2'b00};
      rd_addr = {22'b0, wr_addr[9:2] + word_idx_t'(1 + next_rand() % 255), 2'b00};
      fork
        do_write(wr_addr, next_rand(), axil_strb_t'(next_rand()));
        do_read(rd_addr);
      join
    end

    $display("TEST PASS");
    $finish;
  end

endmodule

// ==== sram_axil_top.sv ====
`timescale 1ns/1ps

module sram_axil_top (
  input  logic               clk,
  input  logic               rst,
  input  axil_pkg::axil_ar_t ar,
  input  logic               arvalid,
  output logic               arready,
  output axil_pkg::axil_r_t  r,
  output logic               rvalid,
  input  logic               rready,
  input  axil_pkg::axil_aw_t aw,
  input  logic               awvalid,
  output logic               awready,
  input  axil_pkg::axil_w_t  w,
  input  logic               wvalid,
  output logic               wready,
  output axil_pkg::axil_b_t  b,
  output logic               bvalid,
  input  logic               bready
);
  import axil_pkg::*;
  import sram_pkg::*;

  wait_t      wait_val;
  logic       rd_start;
  logic       rd_done;
  logic       wr_start;
  logic       wr_done;
  logic       rd_en;
  word_idx_t  rd_idx;
  axil_data_t rd_data;
  logic       wr_en;
  word_idx_t  wr_idx;
  axil_data_t wr_data;
  axil_strb_t wr_strb;

  sram_ctrl sram_ctrl_i (
    .clk     (clk),
    .rst     (rst),
    .ar      (ar),
    .arvalid (arvalid),
    .arready (arready),
    .r       (r),
    .rvalid  (rvalid),
    .rready  (rready),
    .aw      (aw),
    .awvalid (awvalid),
    .awready (awready),
    .w       (w),
    .wvalid  (wvalid),
    .wready  (wready),
    .b       (b),
    .bvalid  (bvalid),
    .bready  (bready),
    .rd_start(rd_start),
    .rd_done (rd_done),
    .wr_start(wr_start),
    .wr_done (wr_done),
    .rd_en   (rd_en),
    .rd_idx  (rd_idx),
    .rd_data (rd_data),
    .wr_en   (wr_en),
    .wr_idx  (wr_idx),
    .wr_data (wr_data),
    .wr_strb (wr_strb)
  );

  // One wait source shared by both channels
  sram_lfsr sram_lfsr_i (
    .clk     (clk),
    .rst     (rst),
    .wait_val(wait_val)
  );

  sram_latency_timer rd_timer_i (
    .clk     (clk),
    .rst     (rst),
    .start   (rd_start),
    .load_val(wait_val),
    .done    (rd_done)
  );

  sram_latency_timer wr_timer_i (
    .clk     (clk),
    .rst     (rst),
    .start   (wr_start),
    .load_val(wait_val),
    .done    (wr_done)
  );

  sram_array sram_array_i (
    .clk    (clk),
    .rd_en  (rd_en),
    .rd_idx (rd_idx),
    .rd_data(rd_data),
    .wr_en  (wr_en),
    .wr_idx (wr_idx),
    .wr_data(wr_data),
    .wr_strb(wr_strb)
  );

endmodule

// ==== sram_ctrl.sv ====
`timescale 1ns/1ps

module sram_ctrl (
  input  logic                 clk,
  input  logic                 rst,
  // Read address / data
  input  axil_pkg::axil_ar_t   ar,
  input  logic                 arvalid,
  output logic                 arready,
  output axil_pkg::axil_r_t    r,
  output logic                 rvalid,
  input  logic                 rready,
  // Write address / data / response
  input  axil_pkg::axil_aw_t   aw,
  input  logic                 awvalid,
  output logic                 awready,
  input  axil_pkg::axil_w_t    w,
  input  logic                 wvalid,
  output logic                 wready,
  output axil_pkg::axil_b_t    b,
  output logic                 bvalid,
  input  logic                 bready,
  // Latency timers
  output logic                 rd_start,
  input  logic                 rd_done,
  output logic                 wr_start,
  input  logic                 wr_done,
  // Array
  output logic                 rd_en,
  output sram_pkg::word_idx_t  rd_idx,
  input  axil_pkg::axil_data_t rd_data,
  output logic                 wr_en,
  output sram_pkg::word_idx_t  wr_idx,
  output axil_pkg::axil_data_t wr_data,
  output axil_pkg::axil_strb_t wr_strb
);
  import axil_pkg::*;
  import sram_pkg::*;

  rd_state_t  rd_state, rd_state_nxt;
  wr_state_t  wr_state, wr_state_nxt;

  word_idx_t  rd_idx_q;
  logic       rd_err_q;
  word_idx_t  wr_idx_q;
  logic       wr_err_q;
  axil_data_t wr_data_q;
  axil_strb_t wr_strb_q;

  // --------------------
  // Read channel

  always_ff @(posedge clk) begin
    if (rst) begin
      rd_state <= RD_IDLE;
    end else begin
      rd_state <= rd_state_nxt;
    end
  end

  always_ff @(posedge clk) begin
    if (arvalid && arready) begin
      rd_idx_q <= ar.addr[WORD_IDX_W+1:2];  // Drop byte offset
      rd_err_q <= ar.addr >= axil_addr_t'(MEM_WORDS * 4);
    end
  end

  always_comb begin
    rd_state_nxt = rd_state;
    case (rd_state)
      RD_IDLE:   if (arvalid) rd_state_nxt = RD_WAIT;
      RD_WAIT:   if (rd_done) rd_state_nxt = RD_ACCESS;
      RD_ACCESS: rd_state_nxt = RD_RESP;
      RD_RESP:   if (rready) rd_state_nxt = RD_IDLE;
      default:   rd_state_nxt = RD_IDLE;
    endcase
  end

  assign arready  = (rd_state == RD_IDLE);
  assign rd_start = arvalid && arready;  // Timer loads on the accept edge
  assign rd_en    = (rd_state == RD_ACCESS) && !rd_err_q;
  assign rd_idx   = rd_idx_q;
  assign rvalid   = (rd_state == RD_RESP);
  assign r.data   = rd_err_q ? '0 : rd_data;
  assign r.resp   = rd_err_q ? RESP_SLVERR : RESP_OKAY;

  // --------------------
  // Write channel

  always_ff @(posedge clk) begin
    if (rst) begin
      wr_state <= WR_IDLE;
    end else begin
      wr_state <= wr_state_nxt;
    end
  end

  always_ff @(posedge clk) begin
    if (awvalid && awready) begin
      wr_idx_q <= aw.addr[WORD_IDX_W+1:2];
      wr_err_q <= aw.addr >= axil_addr_t'(MEM_WORDS * 4);
    end
    if (wvalid && wready) begin
      wr_data_q <= w.data;
      wr_strb_q <= w.strb;
    end
  end

  // Address first, then data
  always_comb begin
    wr_state_nxt = wr_state;
    case (wr_state)
      WR_IDLE:   if (awvalid) wr_state_nxt = WR_DATA;
      WR_DATA:   if (wvalid) wr_state_nxt = WR_WAIT;
      WR_WAIT:   if (wr_done) wr_state_nxt = WR_ACCESS;
      WR_ACCESS: wr_state_nxt = WR_RESP;
      WR_RESP:   if (bready) wr_state_nxt = WR_IDLE;
      default:   wr_state_nxt = WR_IDLE;
    endcase
  end

  assign awready  = (wr_state == WR_IDLE);
  assign wready   = (wr_state == WR_DATA);
  assign wr_start = wvalid && wready;
  assign wr_en    = (wr_state == WR_ACCESS) && !wr_err_q;  // No write when out of range
  assign wr_idx   = wr_idx_q;
  assign wr_data  = wr_data_q;
  assign wr_strb  = wr_strb_q;
  assign bvalid   = (wr_state == WR_RESP);
  assign b.resp   = wr_err_q ? RESP_SLVERR : RESP_OKAY;

  // --------------------
  // Protocol checks

  a_r_hold: assert property (
    @(posedge clk) disable iff (rst)
    rvalid && !rready |=> rvalid && $stable(r)
  );

  a_b_hold: assert property (
    @(posedge clk) disable iff (rst)
    bvalid && !bready |=> bvalid && $stable(b)
  );

  // Array write lands within the longest timer wait
  a_wr_latency: assert property (
    @(posedge clk) disable iff (rst)
    wr_start && !wr_err_q |-> ##[3:10] wr_en
  );

endmodule

// ==== sram_array.sv ====
`timescale 1ns/1ps

module sram_array (
  input  logic                 clk,
  input  logic                 rd_en,
  input  sram_pkg::word_idx_t  rd_idx,
  output axil_pkg::axil_data_t rd_data,
  input  logic                 wr_en,
  input  sram_pkg::word_idx_t  wr_idx,
  input  axil_pkg::axil_data_t wr_data,
  input  axil_pkg::axil_strb_t wr_strb
);
  import axil_pkg::*;
  import sram_pkg::*;

  axil_data_t mem [MEM_WORDS];

  initial begin
    for (int i = 0; i < MEM_WORDS; i++) begin
      mem[i] = '0;
    end
  end

  // --------------------
  // Read port

  // Same-cycle write to this word is not seen here
  always_ff @(posedge clk) begin
    if (rd_en) begin
      rd_data <= mem[rd_idx];
    end
  end

  // --------------------
  // Write port

  always_ff @(posedge clk) begin
    if (wr_en) begin
      for (int lane = 0; lane < STRB_W; lane++) begin
        if (wr_strb[lane]) begin
          mem[wr_idx][8*lane +: 8] <= wr_data[8*lane +: 8];  // Byte lane
        end
      end
    end
  end

endmodule

// ==== sram_latency_timer.sv ====
`timescale 1ns/1ps

module sram_latency_timer (
  input  logic            clk,
  input  logic            rst,
  input  logic            start,
  input  sram_pkg::wait_t load_val,
  output logic            done
);
  import sram_pkg::*;

  wait_t cnt;
  logic  busy;

  // Expires load_val + 1 cycles after the start edge
  always_ff @(posedge clk) begin
    if (rst) begin
      cnt  <= '0;
      busy <= 1'b0;
      done <= 1'b0;
    end else begin
      done <= 1'b0;  // Single-cycle pulse
      if (start) begin
        cnt  <= load_val;
        busy <= 1'b1;
      end else if (busy) begin
        if (cnt == '0) begin
          busy <= 1'b0;
          done <= 1'b1;
        end else begin
          cnt <= cnt - 1'b1;
        end
      end
    end
  end

  // Controller must wait for done before the next start
  a_no_restart: assert property (
    @(posedge clk) disable iff (rst)
    start |-> !busy
  );

  // Done follows every start within the longest wait
  a_done_follows: assert property (
    @(posedge clk) disable iff (rst)
    start |-> ##[2:9] done
  );

endmodule

// ==== sram_lfsr.sv ====
`timescale 1ns/1ps

module sram_lfsr (
  input  logic            clk,
  input  logic            rst,
  output sram_pkg::wait_t wait_val
);
  import sram_pkg::*;

  logic [LFSR_W-1:0] lfsr;
  logic              feedback;

  // x^16 + x^14 + x^13 + x^11 + 1, maximal length
  assign feedback = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];

  always_ff @(posedge clk) begin
    if (rst) begin
      lfsr <= LFSR_SEED;
    end else begin
      lfsr <= {lfsr[LFSR_W-2:0], feedback};
    end
  end

  assign wait_val = lfsr[WAIT_W-1:0];

  // All-zero state would lock up the sequence
  a_lfsr_nonzero: assert property (
    @(posedge clk) disable iff (rst)
    lfsr != '0
  );

endmodule

// ==== sram_pkg.sv ====
package sram_pkg;

  // Memory geometry
  localparam int MEM_WORDS  = 256;
  localparam int WORD_IDX_W = 8;

  typedef logic [WORD_IDX_W-1:0] word_idx_t;

  // Access latency, up to 7 extra cycles
  localparam int WAIT_W = 3;

  typedef logic [WAIT_W-1:0] wait_t;

  localparam int            LFSR_W    = 16;
  localparam logic [15:0]   LFSR_SEED = 16'hace1;  // Any nonzero value

  // --------------------
  // Channel FSMs

  typedef enum logic [1:0] {
    RD_IDLE,
    RD_WAIT,
    RD_ACCESS,
    RD_RESP
  } rd_state_t;

  typedef enum logic [2:0] {
    WR_IDLE,
    WR_DATA,
    WR_WAIT,
    WR_ACCESS,
    WR_RESP
  } wr_state_t;

endpackage

// ==== axil_pkg.sv ====
package axil_pkg;

  // Bus widths
  localparam int ADDR_W = 32;
  localparam int DATA_W = 32;
  localparam int STRB_W = 4;  // One bit per byte lane

  typedef logic [ADDR_W-1:0] axil_addr_t;
  typedef logic [DATA_W-1:0] axil_data_t;
  typedef logic [STRB_W-1:0] axil_strb_t;
  typedef logic [1:0]        axil_resp_t;

  localparam axil_resp_t RESP_OKAY   = 2'd0;
  localparam axil_resp_t RESP_SLVERR = 2'd2;

  // --------------------
  // Channel payloads

  typedef struct packed {
    axil_addr_t addr;
  } axil_ar_t;

  typedef struct packed {
    axil_addr_t addr;
  } axil_aw_t;

  typedef struct packed {
    axil_data_t data;
    axil_strb_t strb;
  } axil_w_t;

  typedef struct packed {
    axil_data_t data;
    axil_resp_t resp;
  } axil_r_t;

  typedef struct packed {
    axil_resp_t resp;
  } axil_b_t;

endpackage
